// ==== logic/ex_config.svh ====
// EX stage configuration: datapath widths and operation encodings
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define EX_DATA_W 32
`define EX_MM_W   64

// alu operations, bit 0 doubles as shift direction (1 = right)
`define EX_ALUK_ADD 2'b00
`define EX_ALUK_AND 2'b01
`define EX_ALUK_OR  2'b10
`define EX_ALUK_XOR 2'b11

// stack pop increment in bytes
`define EX_POP_2  2'b00
`define EX_POP_4  2'b01
`define EX_POP_8  2'b10
`define EX_POP_12 2'b11

// zero flag position in the flags word
`define EX_ZF_BIT 6

`endif

// ==== logic/ex_functional_unit.sv ====
// EX functional unit: 32-bit ALU, packed MMX add, shifter, count and pop adders
`include "ex_config.svh"

module ex_functional_unit
	import ex_pkg::*;
(
	input  logic [1:0]            aluk,
	input  logic [1:0]            datasize,
	input  logic [1:0]            pop_size,
	input  logic [`EX_DATA_W-1:0] ex_a, ex_b, b, ex_c, count,
	input  ex_flags_u             flags_fwd,
	input  logic [`EX_MM_W-1:0]   ex_mm_a, ex_mm_b,
	input  logic                  mm_aluk,
	output logic [`EX_DATA_W-1:0] alu_result,
	output ex_flags_u             alu_flags,
	output logic [`EX_MM_W-1:0]   mm_result,
	output logic [`EX_DATA_W-1:0] shift_result,
	output ex_flags_u             shift_flags,
	output logic [`EX_DATA_W-1:0] count_minus_one,
	output logic [`EX_DATA_W-1:0] sp_pop
);

	localparam int W = `EX_DATA_W;

	logic [W:0]     add_sum;
	logic           alu_cf, alu_of;
	logic [`EX_MM_W-1:0] mm_bytes, mm_words;
	logic [W-1:0]   size_mask, shift_opnd, pop_inc;
	logic [W:0]     carry_pos;
	logic [2*W-1:0] shl_ext, shr_ext;
	logic           shift_cf;

	// status bits from a result, the rest pass through from forwarding
	function automatic ex_flags_u make_flags(ex_flags_u fwd, logic [W-1:0] res,
			logic cf, logic of);
		ex_flags_u f;
		f = fwd;
		f.bits.cf = cf;
		f.bits.pf = ~^res[7:0];
		f.bits.zf = (res == '0);
		f.bits.sf = res[W-1];
		f.bits.of = of;
		return f;
	endfunction

	// ----------------------------------------------------------------------
	// alu
	// ----------------------------------------------------------------------
	assign add_sum = {1'b0, ex_a} + {1'b0, b};

	always_comb begin
		alu_cf = 1'b0;
		alu_of = 1'b0;
		case (aluk)
			`EX_ALUK_ADD: begin
				alu_result = add_sum[W-1:0];
				alu_cf = add_sum[W];
				alu_of = (ex_a[W-1] == b[W-1]) && (add_sum[W-1] != ex_a[W-1]);
			end
			`EX_ALUK_AND: alu_result = ex_a & b;
			`EX_ALUK_OR:  alu_result = ex_a | b;
			default:      alu_result = ex_a ^ b;
		endcase
	end

	assign alu_flags = make_flags(flags_fwd, alu_result, alu_cf, alu_of);

	// packed adds, lanes never carry into each other
	for (genvar i = 0; i < `EX_MM_W / 8; i++) begin : g_pbyte
		assign mm_bytes[i*8 +: 8] = ex_mm_a[i*8 +: 8] + ex_mm_b[i*8 +: 8];
	end
	for (genvar i = 0; i < `EX_MM_W / 16; i++) begin : g_pword
		assign mm_words[i*16 +: 16] = ex_mm_a[i*16 +: 16] + ex_mm_b[i*16 +: 16];
	end
	assign mm_result = mm_aluk ? mm_words : mm_bytes;

	// ----------------------------------------------------------------------
	// shifter
	// ----------------------------------------------------------------------
	// datasize 0 byte, 1 word, otherwise dword
	always_comb begin
		case (datasize)
			2'b00:   size_mask = W'('hff);
			2'b01:   size_mask = W'('hffff);
			default: size_mask = '1;
		endcase
	end

	assign shift_opnd = ex_a & size_mask;
	assign shl_ext = {{W{1'b0}}, shift_opnd} << ex_b[4:0];
	assign shr_ext = {shift_opnd, {W{1'b0}}} >> ex_b[4:0];
	// one-hot bit just above the operand size
	assign carry_pos = {1'b0, size_mask} + 1'b1;

	// carry is the last bit shifted out
	assign shift_cf = aluk[0] ? shr_ext[W-1] : |(shl_ext[W:0] & carry_pos);
	assign shift_result = (aluk[0] ? shr_ext[2*W-1:W] : shl_ext[W-1:0]) & size_mask;
	assign shift_flags = make_flags(flags_fwd, shift_result, shift_cf, 1'b0);

	// count and stack pointer
	always_comb begin
		case (pop_size)
			`EX_POP_2: pop_inc = W'(2);
			`EX_POP_4: pop_inc = W'(4);
			`EX_POP_8: pop_inc = W'(8);
			default:   pop_inc = W'(12);
		endcase
	end

	assign count_minus_one = count - 1'b1;
	assign sp_pop = ex_c + pop_inc;

endmodule

// ==== logic/ex_operand_select.sv ====
// EX operand select: CMPS temporary register, B operand and repeat count
`include "ex_config.svh"

module ex_operand_select (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  ex_v,
	input  logic                  is_cmps_first,
	input  logic                  is_cmps_second,
	input  logic                  repne_steady,
	input  logic [`EX_DATA_W-1:0] ex_a,
	input  logic [`EX_DATA_W-1:0] ex_b,
	input  logic [`EX_DATA_W-1:0] ex_c,
	input  logic [`EX_DATA_W-1:0] count_fwd,
	output logic [`EX_DATA_W-1:0] b,
	output logic [`EX_DATA_W-1:0] count
);

	logic [`EX_DATA_W-1:0] cmps_temp;

	// first micro-op parks its A operand for the second
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			cmps_temp <= '0;
		end else if (is_cmps_first && ex_v) begin
			cmps_temp <= ex_a;
		end
	end

	assign b = is_cmps_second ? cmps_temp : ex_b;

	// steady-state repne takes the count from the forwarding path
	assign count = repne_steady ? count_fwd : ex_c;

	// the two halves of a cmps never share a cycle
	a_cmps_exclusive : assert property (
		@(posedge CLK) disable iff (!rst_n)
		!(is_cmps_first && is_cmps_second)
	) else $error("Error: %0t cmps first and second micro-op flags both set", $time);

endmodule

// ==== logic/ex_pkg.sv ====
// EX stage shared types: the flags word as raw value and as named bits
`include "ex_config.svh"

package ex_pkg;

	// raw view feeds forwarding and writeback,
	// the named view feeds the cmpxchg decision
	typedef union packed {
		logic [`EX_DATA_W-1:0] raw;
		struct packed {
			logic [19:0] rsvd_31_12;
			logic        of;
			logic [2:0]  rsvd_10_8;
			logic        sf;
			logic        zf;
			logic [2:0]  rsvd_5_3;
			logic        pf;
			logic        rsvd_1;
			logic        cf;
		} bits;
	} ex_flags_u;

endpackage

// ==== logic/ex_result_select.sv ====
// EX result select: result A, B and C words, flags and MMX result
`include "ex_config.svh"

module ex_result_select
	import ex_pkg::*;
(
	input  logic                  is_cmps_first,
	input  logic                  is_cmps_second,
	input  logic                  is_cmpxchg,
	input  logic                  is_xchg,
	input  logic                  pass_a,
	input  logic                  is_alu32,
	input  logic                  is_alu32_flags,
	input  logic                  mux_sp_pop,
	input  logic [`EX_DATA_W-1:0] ex_a, ex_b, ex_c,
	input  logic [`EX_DATA_W-1:0] alu_result,
	input  ex_flags_u             alu_flags,
	input  logic [`EX_MM_W-1:0]   mm_result,
	input  logic [`EX_DATA_W-1:0] shift_result,
	input  ex_flags_u             shift_flags,
	input  logic [`EX_DATA_W-1:0] count_minus_one,
	input  logic [`EX_DATA_W-1:0] sp_pop,
	output logic [`EX_DATA_W-1:0] res_a_next,
	output logic [`EX_DATA_W-1:0] res_b_next,
	output logic [`EX_DATA_W-1:0] res_c_next,
	output ex_flags_u             flags_next,
	output logic [`EX_MM_W-1:0]   mm_next
);

	// result A priority: alu, then b, then a, then c, shifter last
	assign res_a_next = is_alu32 ? alu_result :
		(is_cmps_first || is_xchg) ? ex_b :
		pass_a ? ex_a :
		is_cmpxchg ? ex_c :
		shift_result;

	// swap path for xchg and cmpxchg
	assign res_b_next = (is_cmpxchg || is_xchg) ? ex_a : ex_b;

	// second cmps micro-op retires one iteration of the count
	assign res_c_next = is_cmps_second ? count_minus_one :
		mux_sp_pop ? sp_pop :
		ex_c;

	assign flags_next = is_alu32_flags ? alu_flags : shift_flags;

	assign mm_next = mm_result;

endmodule

// ==== logic/ex_stage.sv ====
// EX stage top: operand select, functional unit, write enables, result mux, WB latch
`include "ex_config.svh"

module ex_stage
	import ex_pkg::*;
(
	input  logic                  CLK,
	input  logic                  rst_n,
	// upstream latch
	input  logic                  ex_v,
	input  logic [`EX_DATA_W-1:0] ex_a, ex_b, ex_c,
	input  logic [`EX_MM_W-1:0]   ex_mm_a, ex_mm_b,
	input  logic [1:0]            aluk, datasize, pop_size,
	input  logic                  is_cmps_first, is_cmps_second, is_cmpxchg, is_xchg,
	input  logic                  pass_a, is_alu32, is_alu32_flags, mux_sp_pop,
	input  logic                  repne_steady,
	input  logic [`EX_DATA_W-1:0] count_fwd,
	input  ex_flags_u             flags_fwd,
	input  logic                  ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write,
	input  logic                  is_repne, repne_terminate,
	// writeback side
	input  logic                  wb_stall,
	output logic                  ld_latches,
	output logic                  wb_v,
	output logic [`EX_DATA_W-1:0] wb_res_a, wb_res_b, wb_res_c,
	output ex_flags_u             wb_flags,
	output logic [`EX_MM_W-1:0]   wb_mm,
	output logic                  wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3,
	output logic                  wb_ld_seg, wb_ld_mm, wb_dcache_write
);

	logic [`EX_DATA_W-1:0] b, count;
	logic [`EX_DATA_W-1:0] alu_result, shift_result, count_minus_one, sp_pop;
	ex_flags_u             alu_flags, shift_flags, flags_next;
	logic [`EX_MM_W-1:0]   mm_result, mm_next;
	logic [`EX_DATA_W-1:0] res_a_next, res_b_next, res_c_next;
	logic                  v_ld_gpr1, v_ld_gpr2, v_ld_gpr3;
	logic                  v_ld_seg, v_ld_mm, v_dcache_write;

	ex_operand_select u_operand_select (.*);

	// packed word add when aluk[0] is set, packed byte add otherwise
	ex_functional_unit u_functional_unit (
		.mm_aluk(aluk[0]),
		.*
	);

	ex_write_enable u_write_enable (.*);

	ex_result_select u_result_select (.*);

	ex_wb_latch u_wb_latch (.*);

endmodule

// ==== logic/ex_wb_latch.sv ====
// EX/WB pipeline latch with stall hold and REPNE valid squash
`include "ex_config.svh"

module ex_wb_latch
	import ex_pkg::*;
(
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  wb_stall,
	input  logic                  ex_v,
	input  logic                  is_repne,
	input  logic                  repne_terminate,
	input  logic [`EX_DATA_W-1:0] res_a_next, res_b_next, res_c_next,
	input  ex_flags_u             flags_next,
	input  logic [`EX_MM_W-1:0]   mm_next,
	input  logic                  v_ld_gpr1, v_ld_gpr2, v_ld_gpr3,
	input  logic                  v_ld_seg, v_ld_mm, v_dcache_write,
	output logic                  ld_latches,
	output logic                  wb_v,
	output logic [`EX_DATA_W-1:0] wb_res_a, wb_res_b, wb_res_c,
	output ex_flags_u             wb_flags,
	output logic [`EX_MM_W-1:0]   wb_mm,
	output logic                  wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3,
	output logic                  wb_ld_seg, wb_ld_mm, wb_dcache_write
);

	logic v_next;

	// upstream holds whenever writeback stalls
	assign ld_latches = !wb_stall;

	// repne iterations only retire on the terminating pass
	assign v_next = is_repne ? (ex_v && repne_terminate) : ex_v;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_v <= 1'b0;
			wb_res_a <= '0;
			wb_res_b <= '0;
			wb_res_c <= '0;
			wb_flags <= '0;
			wb_mm <= '0;
			wb_ld_gpr1 <= 1'b0;
			wb_ld_gpr2 <= 1'b0;
			wb_ld_gpr3 <= 1'b0;
			wb_ld_seg <= 1'b0;
			wb_ld_mm <= 1'b0;
			wb_dcache_write <= 1'b0;
		end else if (ld_latches) begin
			wb_v <= v_next;
			wb_res_a <= res_a_next;
			wb_res_b <= res_b_next;
			wb_res_c <= res_c_next;
			wb_flags <= flags_next;
			wb_mm <= mm_next;
			wb_ld_gpr1 <= v_ld_gpr1;
			wb_ld_gpr2 <= v_ld_gpr2;
			wb_ld_gpr3 <= v_ld_gpr3;
			wb_ld_seg <= v_ld_seg;
			wb_ld_mm <= v_ld_mm;
			wb_dcache_write <= v_dcache_write;
		end
	end

	// ----------------------------------------------------------------------
	// a stalled edge must not disturb what writeback is looking at
	// ----------------------------------------------------------------------
	a_stall_hold : assert property (
		@(posedge CLK) disable iff (!rst_n)
		(rst_n && wb_stall) |=> $stable({wb_v, wb_res_a, wb_res_b, wb_res_c,
			wb_flags.raw, wb_mm, wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3,
			wb_ld_seg, wb_ld_mm, wb_dcache_write})
	) else $error("Error: %0t wb latch changed during stall", $time);

endmodule

// ==== logic/ex_write_enable.sv ====
// EX write enables: CMPXCHG zero-flag override and valid gating
module ex_write_enable
	import ex_pkg::*;
(
	input  logic      ex_v,
	input  logic      is_cmpxchg,
	input  ex_flags_u alu_flags,
	input  logic      ld_gpr1,
	input  logic      ld_gpr2,
	input  logic      ld_gpr3,
	input  logic      ld_seg,
	input  logic      ld_mm,
	input  logic      dcache_write,
	output logic      v_ld_gpr1,
	output logic      v_ld_gpr2,
	output logic      v_ld_gpr3,
	output logic      v_ld_seg,
	output logic      v_ld_mm,
	output logic      v_dcache_write
);

	logic zf;
	logic gpr1, gpr2, dcache;

	assign zf = alu_flags.bits.zf;

	always_comb begin
		// cmpxchg: equal writes dest and memory, unequal loads the accumulator
		gpr1 = is_cmpxchg ? (ld_gpr1 && zf) : ld_gpr1;
		gpr2 = is_cmpxchg ? (ld_gpr2 && !zf) : ld_gpr2;
		dcache = is_cmpxchg ? (dcache_write && zf) : dcache_write;

		// nothing leaves the stage for a bubble
		v_ld_gpr1 = ex_v && gpr1;
		v_ld_gpr2 = ex_v && gpr2;
		v_ld_gpr3 = ex_v && ld_gpr3;
		v_ld_seg = ex_v && ld_seg;
		v_ld_mm = ex_v && ld_mm;
		v_dcache_write = ex_v && dcache;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the EX stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal -f vlog.f \
	--top-module tb_ex_stage -o sim_ex_stage

./obj_dir/sim_ex_stage | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== testbench/tb_ex_stage.sv ====
// EX stage testbench: directed and random stimulus against a reference model
`include "ex_config.svh"

module tb_ex_stage
	import ex_pkg::*;
();

	localparam int CYCLE_LIMIT = 400;

	logic CLK, rst_n, wb_stall;
	logic ex_v, is_cmps_first, is_cmps_second, is_cmpxchg, is_xchg;
	logic pass_a, is_alu32, is_alu32_flags, mux_sp_pop, repne_steady;
	logic ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write;
	logic is_repne, repne_terminate;
	logic [1:0] aluk, datasize, pop_size;
	logic [`EX_DATA_W-1:0] ex_a, ex_b, ex_c, count_fwd;
	logic [`EX_MM_W-1:0] ex_mm_a, ex_mm_b;
	ex_flags_u flags_fwd;
	logic ld_latches, wb_v;
	logic [`EX_DATA_W-1:0] wb_res_a, wb_res_b, wb_res_c;
	ex_flags_u wb_flags;
	logic [`EX_MM_W-1:0] wb_mm;
	logic wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3, wb_ld_seg, wb_ld_mm, wb_dcache_write;

	// reference model
	logic [`EX_DATA_W-1:0] saved_a, opnd_b, pop_bytes;
	logic [`EX_DATA_W-1:0] exp_res_a, exp_res_b, exp_res_c;
	ex_flags_u exp_alu_flags, exp_flags;
	logic [`EX_MM_W-1:0] exp_mm;
	// valid, gpr1, gpr2, gpr3, seg, mm, dcache
	logic [6:0] exp_ctl;
	integer seed, errors, cycles;

	ex_stage u_ex_stage (.*);

	function automatic logic [31:0] alu_model(logic [1:0] op, logic [31:0] a, logic [31:0] b);
		case (op)
			`EX_ALUK_ADD: return a + b;
			`EX_ALUK_AND: return a & b;
			`EX_ALUK_OR: return a | b;
			default: return a ^ b;
		endcase
	endfunction

	function automatic ex_flags_u flags_model(logic [1:0] op, logic [31:0] a, logic [31:0] b,
			ex_flags_u fwd);
		logic [32:0] wide;
		logic [31:0] r;
		ex_flags_u f;
		wide = {1'b0, a} + {1'b0, b};
		r = alu_model(op, a, b);
		f = fwd;
		f.raw[`EX_ZF_BIT] = (r == 32'd0);
		f.bits.sf = r[31];
		f.bits.pf = ~^r[7:0];
		// only the add produces carry and overflow
		f.bits.cf = (op == `EX_ALUK_ADD) && wide[32];
		f.bits.of = (op == `EX_ALUK_ADD) && (a[31] == b[31]) && (r[31] != a[31]);
		return f;
	endfunction

	function automatic logic [63:0] mm_model(logic words, logic [63:0] a, logic [63:0] b);
		logic [63:0] r;
		for (int i = 0; i < 4; i++) begin
			if (words) begin
				r[i*16 +: 16] = a[i*16 +: 16] + b[i*16 +: 16];
			end else begin
				r[i*16 +: 8] = a[i*16 +: 8] + b[i*16 +: 8];
				r[i*16+8 +: 8] = a[i*16+8 +: 8] + b[i*16+8 +: 8];
			end
		end
		return r;
	endfunction

	function automatic logic [31:0] shift_model(logic right, logic [1:0] size, logic [31:0] a,
			logic [4:0] sh);
		logic [31:0] mask;
		mask = (size == 2'b00) ? 32'hff : (size == 2'b01) ? 32'hffff : 32'hffff_ffff;
		return (right ? ((a & mask) >> sh) : ((a & mask) << sh)) & mask;
	endfunction

	function automatic ex_flags_u shift_flags_model(logic right, logic [1:0] size,
			logic [31:0] a, logic [4:0] sh, ex_flags_u fwd);
		int width;
		logic [31:0] opnd, r;
		ex_flags_u f;
		width = (size == 2'b00) ? 8 : (size == 2'b01) ? 16 : 32;
		opnd = a & (32'hffff_ffff >> (32 - width));
		r = shift_model(right, size, a, sh);
		f = fwd;
		f.raw[`EX_ZF_BIT] = (r == 32'd0);
		f.bits.sf = r[31];
		f.bits.pf = ~^r[7:0];
		f.bits.of = 1'b0;
		// carry is the last operand bit pushed out
		if (sh == 5'd0) begin
			f.bits.cf = 1'b0;
		end else if (right) begin
			f.bits.cf = opnd[sh - 5'd1];
		end else if (sh <= width) begin
			f.bits.cf = opnd[width - sh];
		end else begin
			f.bits.cf = 1'b0;
		end
		return f;
	endfunction

	// cmps first micro-op keeps its A operand
	always @(posedge CLK) begin
		if (!rst_n) begin
			saved_a <= '0;
		end else if (is_cmps_first && ex_v) begin
			saved_a <= ex_a;
		end
	end

	// expected WB values for the op presented this cycle
	always_comb begin
		opnd_b = is_cmps_second ? saved_a : ex_b;
		exp_alu_flags = flags_model(aluk, ex_a, opnd_b, flags_fwd);
		exp_flags = is_alu32_flags ? exp_alu_flags :
			shift_flags_model(aluk[0], datasize, ex_a, ex_b[4:0], flags_fwd);
		if (is_alu32) begin
			exp_res_a = alu_model(aluk, ex_a, opnd_b);
		end else if (is_cmps_first || is_xchg) begin
			exp_res_a = ex_b;
		end else if (pass_a) begin
			exp_res_a = ex_a;
		end else if (is_cmpxchg) begin
			exp_res_a = ex_c;
		end else begin
			exp_res_a = shift_model(aluk[0], datasize, ex_a, ex_b[4:0]);
		end
		exp_res_b = (is_cmpxchg || is_xchg) ? ex_a : ex_b;
		pop_bytes = (pop_size == `EX_POP_2) ? 2 : (pop_size == `EX_POP_4) ? 4 :
			(pop_size == `EX_POP_8) ? 8 : 12;
		if (is_cmps_second) begin
			exp_res_c = (repne_steady ? count_fwd : ex_c) - 32'd1;
		end else begin
			exp_res_c = mux_sp_pop ? ex_c + pop_bytes : ex_c;
		end
		exp_mm = mm_model(aluk[0], ex_mm_a, ex_mm_b);
		exp_ctl[6] = ex_v && (!is_repne || repne_terminate);
		exp_ctl[5:0] = {6{ex_v}} & {
			ld_gpr1 && (!is_cmpxchg || exp_alu_flags.raw[`EX_ZF_BIT]),
			ld_gpr2 && !(is_cmpxchg && exp_alu_flags.raw[`EX_ZF_BIT]),
			ld_gpr3, ld_seg, ld_mm,
			dcache_write && (!is_cmpxchg || exp_alu_flags.raw[`EX_ZF_BIT])};
	end

	task automatic report_error(input string msg);
		errors++;
		$display("Error: %0t %s", $time, msg);
	endtask

	// ----------------------------------------------------------------------
	// checkers
	// ----------------------------------------------------------------------
	a_reset : assert property (@(posedge CLK) $rose(rst_n) |-> !(wb_v || wb_ld_gpr1 ||
		wb_ld_gpr2 || wb_ld_gpr3 || wb_ld_seg || wb_ld_mm || wb_dcache_write))
		else report_error("wb valid or enable set after reset");

	a_results : assert property (@(posedge CLK) disable iff (!rst_n)
		!wb_stall |=> wb_res_a == $past(exp_res_a) && wb_res_b == $past(exp_res_b) &&
		wb_res_c == $past(exp_res_c))
		else report_error("wb result word mismatch");

	a_flags_mm : assert property (@(posedge CLK) disable iff (!rst_n)
		!wb_stall |=> wb_flags.raw == $past(exp_flags.raw) && wb_mm == $past(exp_mm))
		else report_error("wb flags or mmx result mismatch");

	a_enables : assert property (@(posedge CLK) disable iff (!rst_n)
		!wb_stall |=> {wb_v, wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3, wb_ld_seg, wb_ld_mm,
		wb_dcache_write} == $past(exp_ctl))
		else report_error("wb valid or write enable mismatch");

	a_stall_load : assert property (@(posedge CLK) wb_stall |-> !ld_latches)
		else report_error("ld_latches high during stall");

	a_stall_hold : assert property (@(posedge CLK) disable iff (!rst_n)
		wb_stall |=> $stable(wb_res_a) && $stable(wb_res_b) && $stable(wb_res_c) &&
		$stable(wb_v) && $stable(wb_mm) && $stable(wb_flags.raw))
		else report_error("wb outputs changed during stall");

	// ----------------------------------------------------------------------
	// clock, timeout, stimulus
	// ----------------------------------------------------------------------
	initial begin
		CLK = 1'b0;
		cycles = 0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d", errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic clear_controls();
		ex_v = 1'b1;
		{is_cmps_first, is_cmps_second, is_cmpxchg, is_xchg, pass_a, is_alu32} = '0;
		{mux_sp_pop, repne_steady, is_repne, repne_terminate} = '0;
		{ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write} = '0;
		is_alu32_flags = 1'b1;
		aluk = `EX_ALUK_ADD;
		datasize = 2'b10;
		pop_size = `EX_POP_2;
	endtask

	task automatic next_op();
		@(negedge CLK);
		clear_controls();
	endtask

	// capture happens on the first edge with ld_latches high
	task automatic wait_capture();
		do @(posedge CLK); while (!ld_latches);
	endtask

	initial begin
		logic [`EX_DATA_W-1:0] first_a;
		seed = 32'hd53d;
		errors = 0;
		rst_n = 1'b0;
		wb_stall = 1'b0;
		{ex_a, ex_b, ex_c, count_fwd} = '0;
		{ex_mm_a, ex_mm_b} = '0;
		flags_fwd = '0;
		clear_controls();
		ex_v = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;

		// random alu and packed adds, every fourth one with equal operands
		for (int i = 0; i < 16; i++) begin
			next_op();
			is_alu32 = 1'b1;
			ld_gpr1 = 1'b1;
			ld_mm = 1'b1;
			aluk = (i % 4 == 0) ? `EX_ALUK_XOR : 2'($random(seed));
			ex_a = $random(seed);
			ex_b = (i % 4 == 0) ? ex_a : $random(seed);
			ex_mm_a = {$random(seed), $random(seed)};
			ex_mm_b = {$random(seed), $random(seed)};
			flags_fwd = $random(seed);
			wait_capture();
		end

		// shifter left and right at byte, word and dword size
		for (int s = 0; s < 6; s++) begin
			next_op();
			is_alu32_flags = 1'b0;
			ld_gpr1 = 1'b1;
			aluk = 2'(s % 2);
			datasize = 2'(s / 2);
			ex_a = $random(seed);
			ex_b = {27'($random(seed)), 5'(s * 5 + 1)};
			flags_fwd = $random(seed);
			wait_capture();
		end

		// cmps pair with an unrelated op between the halves
		next_op();
		is_cmps_first = 1'b1;
		ex_a = $random(seed);
		ex_b = $random(seed);
		first_a = ex_a;
		wait_capture();
		next_op();
		pass_a = 1'b1;
		ex_a = ~first_a;
		wait_capture();
		for (int k = 0; k < 3; k++) begin
			next_op();
			is_cmps_second = 1'b1;
			is_alu32 = 1'b1;
			aluk = `EX_ALUK_XOR;
			ld_gpr3 = 1'b1;
			ex_a = first_a;
			ex_b = ~first_a;
			ex_c = 32'd9;
			count_fwd = 32'd5;
			repne_steady = (k > 0);
			is_repne = (k > 0);
			repne_terminate = (k == 2);
			wait_capture();
		end

		// cmpxchg equal then unequal, then xchg
		for (int k = 0; k < 2; k++) begin
			next_op();
			is_cmpxchg = 1'b1;
			aluk = `EX_ALUK_XOR;
			{ld_gpr1, ld_gpr2, dcache_write} = 3'b111;
			ex_a = $random(seed);
			ex_b = (k == 0) ? ex_a : ~ex_a;
			ex_c = $random(seed);
			wait_capture();
		end
		next_op();
		is_xchg = 1'b1;
		{ld_gpr1, ld_gpr2} = 2'b11;
		ex_a = $random(seed);
		ex_b = $random(seed);
		wait_capture();

		// bubble with every enable requested
		next_op();
		ex_v = 1'b0;
		pass_a = 1'b1;
		{ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write} = '1;
		wait_capture();

		// stall for three edges on a fresh op
		next_op();
		pass_a = 1'b1;
		ex_a = $random(seed);
		wait_capture();
		next_op();
		pass_a = 1'b1;
		ex_a = $random(seed);
		wb_stall = 1'b1;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		wb_stall = 1'b0;
		wait_capture();

		for (int p = 0; p < 4; p++) begin
			next_op();
			pass_a = 1'b1;
			mux_sp_pop = 1'b1;
			ld_gpr3 = 1'b1;
			pop_size = 2'(p);
			ex_c = $random(seed);
			wait_capture();
		end

		next_op();
		ex_v = 1'b0;
		repeat (2) @(posedge CLK);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/ex_pkg.sv
logic/ex_operand_select.sv
logic/ex_functional_unit.sv
logic/ex_write_enable.sv
logic/ex_result_select.sv
logic/ex_wb_latch.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv
